/* rv_isa_pkg.sv */
package rv_isa_pkg;

	localparam int unsigned xlen       = 32;            // data and address width
	localparam int unsigned reg_addr_w = 5;             // 32 architectural registers
	localparam logic [31:0] nop_instr  = 32'h0000_0013; // addi x0, x0, 0

	// major opcodes, bits [6:0] of every instruction
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111
	} opcode_e;

	// func3 of OP / OP_IMM
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101; // func7[5] picks arithmetic
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	// func3 of BRANCH
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	typedef struct packed {
		logic [6:0]            func7;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            func3;
		logic [reg_addr_w-1:0] rd;
		opcode_e               opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]           imm_11_0;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            func3;
		logic [reg_addr_w-1:0] rd;
		opcode_e               opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]            imm_11_5;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            func3;
		logic [4:0]            imm_4_0;
		opcode_e               opcode;
	} s_fmt_t;

	typedef struct packed {
		logic                  imm_12;
		logic [5:0]            imm_10_5;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            func3;
		logic [3:0]            imm_4_1;
		logic                  imm_11;   // sits where rd[0] would be
		opcode_e               opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]           imm_31_12;
		logic [reg_addr_w-1:0] rd;
		opcode_e               opcode;
	} u_fmt_t;

	typedef struct packed {
		logic                  imm_20;
		logic [9:0]            imm_10_1;
		logic                  imm_11;
		logic [7:0]            imm_19_12;
		logic [reg_addr_w-1:0] rd;
		opcode_e               opcode;
	} j_fmt_t;

	// one instruction word, viewed through each format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv_instr_u;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b // result is operand b, for lui
	} alu_op_e;

endpackage

/* pipe_pkg.sv */
package pipe_pkg;

	// fetch to decode
	typedef struct packed {
		logic                           valid;
		logic [rv_isa_pkg::xlen-1:0]    pc;
		rv_isa_pkg::rv_instr_u          instr;
	} if_id_t;

	// decode to execute
	typedef struct packed {
		logic                              valid;
		logic [rv_isa_pkg::xlen-1:0]       pc;
		logic [rv_isa_pkg::xlen-1:0]       rs1_data;
		logic [rv_isa_pkg::xlen-1:0]       rs2_data;
		logic [rv_isa_pkg::xlen-1:0]       imm;      // sign extended
		rv_isa_pkg::opcode_e               opcode;
		logic [2:0]                        func3;    // width / branch kind for ex and mem
		rv_isa_pkg::alu_op_e               alu_op;
		logic [rv_isa_pkg::reg_addr_w-1:0] rd;
		logic                              rd_we;
	} id_ex_t;

	// writeback into the register file
	typedef struct packed {
		logic                              we;
		logic [rv_isa_pkg::reg_addr_w-1:0] rd;
		logic [rv_isa_pkg::xlen-1:0]       data;
	} wb_t;

	// decode back to fetch
	typedef struct packed {
		logic                        flush;  // taken branch or jump in decode
		logic [rv_isa_pkg::xlen-1:0] target; // next fetch pc when flush is set
	} redirect_t;

endpackage

/* if_id_reg.sv */
`timescale 1ns/100ps

module if_id_reg (
	input  logic             clk,
	input  logic             rst_n,
	input  pipe_pkg::if_id_t i_if,    // from fetch
	input  logic             i_stall, // freeze, from execute
	input  logic             i_flush, // redirect from decode
	output pipe_pkg::if_id_t o_if
);
	import rv_isa_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_if.valid <= 1'b0;
			o_if.instr <= nop_instr; // decode sees a clean nop out of reset
		end else if (!i_stall) begin
			if (i_flush) begin
				// wrong path word fetched during redirect, drop it
				o_if.valid <= 1'b0;
				o_if.pc    <= i_if.pc;
				o_if.instr <= nop_instr;
			end else begin
				o_if <= i_if;
			end
		end
		// stall: hold everything
	end

	// redirect only ever comes from a real instruction held here
	a_flush_needs_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_flush |-> o_if.valid
	) else $error("if_id_reg: flush while held entry is a bubble");

endmodule

/* id_reg_file.sv */
`timescale 1ns/100ps

module id_reg_file (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] i_rs1,
	input  logic [rv_isa_pkg::reg_addr_w-1:0] i_rs2,
	input  pipe_pkg::wb_t                     i_wb,   // write port from writeback
	output logic [rv_isa_pkg::xlen-1:0]       o_rs1_data,
	output logic [rv_isa_pkg::xlen-1:0]       o_rs2_data
);
	import rv_isa_pkg::*;

	logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];
	logic            wr_en; // qualified write, never to x0

	assign wr_en = i_wb.we && (i_wb.rd != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < (1 << reg_addr_w); k++) begin
				regs[k] <= '0;
			end
		end else if (wr_en) begin
			regs[i_wb.rd] <= i_wb.data;
		end
	end

	// x0 reads zero, same cycle write is bypassed to the read
	assign o_rs1_data = (i_rs1 == '0) ? '0 :
		(wr_en && (i_wb.rd == i_rs1)) ? i_wb.data : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 :
		(wr_en && (i_wb.rd == i_rs2)) ? i_wb.data : regs[i_rs2];

	// writeback aimed at x0 must leave it untouched
	a_x0_fixed: assert property (
		@(posedge clk) disable iff (!rst_n)
		(i_wb.we && (i_wb.rd == '0)) |=> (regs[0] == '0)
	) else $error("id_reg_file: x0 changed by writeback");

endmodule

/* id_imm_gen.sv */
`timescale 1ns/100ps

module id_imm_gen (
	input  rv_isa_pkg::rv_instr_u       i_instr,
	output logic [rv_isa_pkg::xlen-1:0] o_imm
);
	import rv_isa_pkg::*;

	always_comb begin
		case (i_instr.r.opcode)
			opc_op_imm, opc_load, opc_jalr: begin // I type
				o_imm = {{20{i_instr.i.imm_11_0[11]}}, i_instr.i.imm_11_0};
			end
			opc_store: begin // S type, imm split around rs1/rs2
				o_imm = {{20{i_instr.s.imm_11_5[6]}}, i_instr.s.imm_11_5, i_instr.s.imm_4_0};
			end
			opc_branch: begin
				// B type, bit 0 implied zero
				o_imm = {{19{i_instr.b.imm_12}},
					i_instr.b.imm_12,
					i_instr.b.imm_11,
					i_instr.b.imm_10_5,
					i_instr.b.imm_4_1,
					1'b0};
			end
			opc_lui, opc_auipc: begin
				o_imm = {i_instr.u.imm_31_12, 12'b0}; // upper 20, low bits zero
			end
			opc_jal: begin
				o_imm = {{11{i_instr.j.imm_20}},
					i_instr.j.imm_20,
					i_instr.j.imm_19_12,
					i_instr.j.imm_11,
					i_instr.j.imm_10_1,
					1'b0};
			end
			default: o_imm = '0; // OP has no immediate
		endcase
	end

endmodule

/* id_alu_ctrl.sv */
`timescale 1ns/100ps

module id_alu_ctrl (
	input  rv_isa_pkg::rv_instr_u i_instr,
	output rv_isa_pkg::alu_op_e   o_alu_op
);
	import rv_isa_pkg::*;

	logic is_op; // register-register form
	logic alt;   // func7[5], sub / sra select

	assign is_op = (i_instr.r.opcode == opc_op);
	assign alt   = i_instr.r.func7[5];

	always_comb begin
		o_alu_op = alu_add; // load, store, auipc, jal, jalr
		case (i_instr.r.opcode)
			opc_op, opc_op_imm: begin
				case (i_instr.r.func3)
					f3_add_sub: o_alu_op = (is_op && alt) ? alu_sub : alu_add; // no subi
					f3_sll:     o_alu_op = alu_sll;
					f3_slt:     o_alu_op = alu_slt;
					f3_sltu:    o_alu_op = alu_sltu;
					f3_xor:     o_alu_op = alu_xor;
					f3_srl_sra: o_alu_op = alt ? alu_sra : alu_srl; // srai has imm[10] set
					f3_or:      o_alu_op = alu_or;
					f3_and:     o_alu_op = alu_and;
					default:    o_alu_op = alu_add;
				endcase
			end
			opc_lui:    o_alu_op = alu_pass_b; // imm straight through
			opc_branch: o_alu_op = alu_sub;    // compare in ex
			default:    o_alu_op = alu_add;
		endcase
	end

endmodule

/* id_branch_unit.sv */
`timescale 1ns/100ps

module id_branch_unit (
	input  logic                        i_valid,
	input  rv_isa_pkg::rv_instr_u       i_instr,
	input  logic [rv_isa_pkg::xlen-1:0] i_pc,
	input  logic [rv_isa_pkg::xlen-1:0] i_rs1_data,
	input  logic [rv_isa_pkg::xlen-1:0] i_rs2_data,
	input  logic [rv_isa_pkg::xlen-1:0] i_imm,
	output pipe_pkg::redirect_t         o_redirect
);
	import rv_isa_pkg::*;

	logic            eq, lt, ltu;
	logic            cond;     // branch condition met
	logic            taken;
	logic [xlen-1:0] jalr_sum;

	assign eq       = (i_rs1_data == i_rs2_data);
	assign lt       = ($signed(i_rs1_data) < $signed(i_rs2_data));
	assign ltu      = (i_rs1_data < i_rs2_data);
	assign jalr_sum = i_rs1_data + i_imm;

	always_comb begin
		case (i_instr.b.func3)
			f3_beq:  cond = eq;
			f3_bne:  cond = !eq;
			f3_blt:  cond = lt;
			f3_bge:  cond = !lt;
			f3_bltu: cond = ltu;
			f3_bgeu: cond = !ltu;
			default: cond = 1'b0; // reserved func3 never branches
		endcase
	end

	always_comb begin
		taken             = 1'b0;
		o_redirect.target = i_pc + i_imm; // branch and jal
		case (i_instr.r.opcode)
			opc_branch: taken = cond;
			opc_jal:    taken = 1'b1;
			opc_jalr: begin
				taken             = 1'b1;
				o_redirect.target = {jalr_sum[xlen-1:1], 1'b0}; // lsb cleared
			end
			default:    taken = 1'b0;
		endcase
		o_redirect.flush = i_valid && taken; // bubbles never redirect
	end

endmodule

/* id_stage.sv */
`timescale 1ns/100ps

module id_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  pipe_pkg::if_id_t    i_if,       // held instruction from if_id_reg
	input  pipe_pkg::wb_t       i_wb,
	input  logic                i_stall,
	output pipe_pkg::id_ex_t    o_ex,       // registered payload to execute
	output pipe_pkg::redirect_t o_redirect  // combinational, to fetch
);
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	rv_instr_u       instr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] imm;
	alu_op_e         alu_op;
	logic            rd_we;
	id_ex_t          ex_d;     // next value of o_ex

	assign instr = i_if.instr;

	// everything but branch and store writes rd
	assign rd_we = !(instr.r.opcode inside {opc_branch, opc_store});

	id_reg_file u_reg_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_rs1      (instr.r.rs1),
		.i_rs2      (instr.r.rs2),
		.i_wb       (i_wb),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	id_imm_gen u_imm_gen (
		.i_instr (instr),
		.o_imm   (imm)
	);

	id_alu_ctrl u_alu_ctrl (
		.i_instr  (instr),
		.o_alu_op (alu_op)
	);

	id_branch_unit u_branch_unit (
		.i_valid    (i_if.valid),
		.i_instr    (instr),
		.i_pc       (i_if.pc),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.i_imm      (imm),
		.o_redirect (o_redirect)
	);

	always_comb begin
		ex_d.valid    = i_if.valid; // taken jumps still go on, for the link write
		ex_d.pc       = i_if.pc;
		ex_d.rs1_data = rs1_data;
		ex_d.rs2_data = rs2_data;
		ex_d.imm      = imm;
		ex_d.opcode   = instr.r.opcode;
		ex_d.func3    = instr.r.func3;
		ex_d.alu_op   = alu_op;
		ex_d.rd       = instr.r.rd;
		ex_d.rd_we    = rd_we;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_ex.valid <= 1'b0; // payload fields left as they are
		end else if (!i_stall) begin
			o_ex <= ex_d;
		end
	end

	// execute is stalled, so it must see the same payload next cycle
	a_hold_on_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		i_stall |=> $stable(o_ex)
	) else $error("id_stage: o_ex changed under stall");

endmodule

/* decode_top.sv */
`timescale 1ns/100ps

module decode_top (
	input  logic                clk,
	input  logic                rst_n,
	input  pipe_pkg::if_id_t    i_if,       // from fetch
	input  pipe_pkg::wb_t       i_wb,       // from writeback
	input  logic                i_stall,    // from execute
	output logic                o_ready,    // to fetch, low means hold i_if
	output pipe_pkg::id_ex_t    o_ex,       // to execute
	output pipe_pkg::redirect_t o_redirect  // to fetch
);
	import pipe_pkg::*;

	if_id_t if_id_q; // held fetch payload

	assign o_ready = !i_stall;

	if_id_reg u_if_id_reg (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_if    (i_if),
		.i_stall (i_stall),
		.i_flush (o_redirect.flush),
		.o_if    (if_id_q)
	);

	id_stage u_id_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_if       (if_id_q),
		.i_wb       (i_wb),
		.i_stall    (i_stall),
		.o_ex       (o_ex),
		.o_redirect (o_redirect)
	);

endmodule

/* tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);
	localparam int half_period  = 4; // 8 ns clock
	localparam int reset_cycles = 3;

	initial begin
		o_clk = 1'b0;
		forever #(half_period) o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (reset_cycles) @(posedge o_clk);
		o_rst_n <= 1'b1; // released on a rising edge, like the stimulus
	end

endmodule

/* tb_decode_top.sv */
`timescale 1ns/100ps

module tb_decode_top;
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	localparam wb_t         no_wb      = '0;
	localparam logic [31:0] wrong_path = 32'h0010_0513; // addi x10, x0, 1

	logic        clk;
	logic        rst_n;
	if_id_t      i_if;
	wb_t         i_wb;
	logic        i_stall;
	logic        o_ready;
	id_ex_t      o_ex;
	redirect_t   o_redirect;

	logic [31:0] shadow [0:31];     // register file as the tb sees it
	if_id_t      m_ifid;            // what the fetch/decode register should hold
	id_ex_t      exp_q [$];         // one entry per unstalled edge
	id_ex_t      next_ex;           // prediction for the coming edge
	logic        have_next = 1'b0;
	logic        prev_stall = 1'b0; // stall that governed the last edge
	id_ex_t      held;              // o_ex one cycle back
	logic [31:0] pc;
	integer      seed;
	int          checked = 0;

	tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

	decode_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_if       (i_if),
		.i_wb       (i_wb),
		.i_stall    (i_stall),
		.o_ready    (o_ready),
		.o_ex       (o_ex),
		.o_redirect (o_redirect)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "stopped at first failing check");
	endtask

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else
			abort_run($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input opcode_e opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input opcode_e opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	// imm is the byte offset, bit 0 dropped
	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	function automatic if_id_t bubble_at(input logic [31:0] at_pc);
		if_id_t b;
		b       = '0;
		b.pc    = at_pc;
		b.instr = nop_instr;
		return b;
	endfunction

	// x0 is zero, a write in the same cycle wins over the stored value
	function automatic logic [31:0] read_shadow(input logic [4:0] idx, input wb_t wb);
		if (idx == 5'd0)
			return 32'h0;
		if (wb.we && (wb.rd == idx))
			return wb.data;
		return shadow[idx];
	endfunction

	// reference decode of entry f while wb is on the write port
	function automatic id_ex_t predict(input if_id_t f, input wb_t wb, output redirect_t rdr);
		logic [31:0] w;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic        taken;
		id_ex_t      e;
		w   = f.instr;
		opc = w[6:0];
		f3  = w[14:12];
		a   = read_shadow(w[19:15], wb);
		b   = read_shadow(w[24:20], wb);
		case (opc)
			opc_op_imm, opc_load, opc_jalr: imm = {{20{w[31]}}, w[31:20]};
			opc_store:          imm = {{20{w[31]}}, w[31:25], w[11:7]};
			opc_branch:         imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			opc_lui, opc_auipc: imm = {w[31:12], 12'h000};
			opc_jal:            imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:            imm = 32'h0;
		endcase
		e.alu_op = alu_add;
		if (opc == opc_op || opc == opc_op_imm) begin
			case (f3)
				3'b000: e.alu_op = (opc == opc_op && w[30]) ? alu_sub : alu_add; // no subi
				3'b001: e.alu_op = alu_sll;
				3'b010: e.alu_op = alu_slt;
				3'b011: e.alu_op = alu_sltu;
				3'b100: e.alu_op = alu_xor;
				3'b101: e.alu_op = w[30] ? alu_sra : alu_srl;
				3'b110: e.alu_op = alu_or;
				default: e.alu_op = alu_and;
			endcase
		end else if (opc == opc_lui) begin
			e.alu_op = alu_pass_b;
		end else if (opc == opc_branch) begin
			e.alu_op = alu_sub;
		end
		taken      = 1'b0;
		rdr.target = f.pc + imm;
		if (opc == opc_branch) begin
			case (f3)
				3'b000:  taken = (a == b);
				3'b001:  taken = (a != b);
				3'b100:  taken = ($signed(a) < $signed(b));
				3'b101:  taken = ($signed(a) >= $signed(b));
				3'b110:  taken = (a < b);
				3'b111:  taken = (a >= b);
				default: taken = 1'b0;
			endcase
		end else if (opc == opc_jal) begin
			taken = 1'b1;
		end else if (opc == opc_jalr) begin
			taken      = 1'b1;
			rdr.target = (a + imm) & 32'hFFFF_FFFE;
		end
		rdr.flush  = f.valid && taken;
		e.valid    = f.valid; // taken jumps still go on
		e.pc       = f.pc;
		e.rs1_data = a;
		e.rs2_data = b;
		e.imm      = imm;
		e.opcode   = opcode_e'(opc);
		e.func3    = f3;
		e.rd       = w[11:7];
		e.rd_we    = !(opc == opc_branch || opc == opc_store);
		return e;
	endfunction

	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [2:0]  f3;
		r  = $random(seed);
		f3 = (r[14:13] == 2'b01) ? 3'b000 : r[14:12]; // no reserved branch kinds
		case ($unsigned($random(seed)) % 9)
			0: return {1'b0, r[30], 5'b0, r[24:7], opc_op};
			1: return {r[31:7], opc_op_imm};
			2: return {r[31:7], opc_load};
			3: return {r[31:7], opc_store};
			4: return {r[31:15], f3, r[11:7], opc_branch};
			5: return {r[31:7], opc_jal};
			6: return {r[31:15], 3'b000, r[11:7], opc_jalr};
			7: return {r[31:7], opc_lui};
			default: return {r[31:7], opc_auipc};
		endcase
	endfunction

	task automatic push_pending();
		if (have_next)
			exp_q.push_back(next_ex);
		have_next = 1'b0;
	endtask

	// one clock of stimulus, the pair fin / stall applies to the next edge
	task automatic cycle(input if_id_t fin, input wb_t wb, input logic stall);
		redirect_t exp_rd;
		id_ex_t    exp_ex;
		@(posedge clk);
		push_pending(); // o_ex for this edge now due
		i_if    <= fin;
		i_wb    <= wb;
		i_stall <= stall;
		@(negedge clk);
		exp_ex = predict(m_ifid, wb, exp_rd);
		check_field("o_ready", 32'(o_ready), 32'(!stall));
		check_field("o_redirect.flush", 32'(o_redirect.flush), 32'(exp_rd.flush));
		if (exp_rd.flush)
			check_field("o_redirect.target", o_redirect.target, exp_rd.target);
		if (!stall) begin
			next_ex   = exp_ex;
			have_next = 1'b1;
			m_ifid    = exp_rd.flush ? bubble_at(fin.pc) : fin; // wrong path dropped
		end
		if (wb.we && (wb.rd != 5'd0))
			shadow[wb.rd] = wb.data;
	endtask

	// fetch holds its word through the stall cycles
	task automatic send(input logic [31:0] word, input wb_t wb, input int nstall);
		if_id_t fin;
		fin.valid = 1'b1;
		fin.pc    = pc;
		fin.instr = word;
		pc        = pc + 32'd4;
		repeat (nstall) cycle(fin, no_wb, 1'b1);
		cycle(fin, wb, 1'b0);
	endtask

	task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
		wb_t w;
		w.we   = 1'b1;
		w.rd   = rd;
		w.data = data;
		cycle(bubble_at(pc), w, 1'b0);
	endtask

	task automatic compare_payload(input id_ex_t got, input id_ex_t exp);
		check_field("o_ex.valid", 32'(got.valid), 32'(exp.valid));
		if (exp.valid) begin
			check_field("o_ex.pc", got.pc, exp.pc);
			check_field("o_ex.rs1_data", got.rs1_data, exp.rs1_data);
			check_field("o_ex.rs2_data", got.rs2_data, exp.rs2_data);
			check_field("o_ex.imm", got.imm, exp.imm);
			check_field("o_ex.opcode", 32'(got.opcode), 32'(exp.opcode));
			check_field("o_ex.func3", 32'(got.func3), 32'(exp.func3));
			check_field("o_ex.alu_op", 32'(got.alu_op), 32'(exp.alu_op));
			check_field("o_ex.rd", 32'(got.rd), 32'(exp.rd));
			check_field("o_ex.rd_we", 32'(got.rd_we), 32'(exp.rd_we));
			checked++;
		end
	endtask

	// compare process, o_ex is settled by the falling edge
	always @(negedge clk) begin : compare_outputs
		id_ex_t e;
		if (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			compare_payload(o_ex, e);
		end else if (prev_stall) begin
			assert (o_ex === held) else
				abort_run($sformatf("CHECK FAILED o_ex under stall: got 0x%h, expected 0x%h",
					o_ex, held));
		end
		prev_stall = i_stall;
		held       = o_ex;
	end

	initial begin
		int          k;
		int          waited;
		logic [31:0] r;
		wb_t         w;
		seed    = 2274;
		pc      = 32'h0000_1000;
		i_if    = bubble_at(32'h0);
		i_wb    = no_wb;
		i_stall = 1'b0;
		m_ifid  = bubble_at(32'h0);
		for (k = 0; k < 32; k++)
			shadow[k] = 32'h0;
		waited = 0;
		while (rst_n !== 1'b1) begin
			assert (waited < 20) else abort_run("reset was never released");
			@(negedge clk);
			waited++;
		end

		write_reg(5'd1, 32'd5);
		write_reg(5'd2, 32'hFFFF_FFF0);
		write_reg(5'd3, 32'd3);
		write_reg(5'd5, 32'h0000_0100);
		for (k = 0; k < 16; k++) // each func3, func7[5] clear and set
			send(enc_r(k[3] ? 7'h20 : 7'h00, 5'd1, 5'd2, k[2:0], 5'd4, opc_op), no_wb, 0);

		send(enc_i(12'hFFB, 5'd1, 3'b000, 5'd6, opc_op_imm), no_wb, 0); // addi -5
		send(enc_i(12'h7FF, 5'd1, 3'b000, 5'd6, opc_op_imm), no_wb, 0);
		send(enc_i(12'h403, 5'd2, 3'b101, 5'd7, opc_op_imm), no_wb, 0); // srai 3
		send(enc_i(12'hFFC, 5'd5, 3'b010, 5'd8, opc_load), no_wb, 0);
		send(enc_s(12'h800, 5'd1, 5'd5, 3'b010), no_wb, 0);             // sw -2048
		send(enc_s(12'h07F, 5'd1, 5'd5, 3'b010), no_wb, 0);
		send({20'hFFFFF, 5'd9, opc_lui}, no_wb, 0);
		send({20'h12345, 5'd9, opc_auipc}, no_wb, 0);

		send(enc_b(13'h0010, 5'd1, 5'd1, 3'b000), no_wb, 0); // beq taken
		send(wrong_path, no_wb, 0);
		send(enc_b(13'h1FF8, 5'd1, 5'd1, 3'b001), no_wb, 0); // bne not taken
		send(enc_b(13'h1FF8, 5'd1, 5'd2, 3'b100), no_wb, 0); // blt, x2 negative
		send(wrong_path, no_wb, 0);
		send(enc_b(13'h0008, 5'd1, 5'd2, 3'b110), no_wb, 0); // bltu not taken
		send(enc_b(13'h0008, 5'd1, 5'd2, 3'b111), no_wb, 0);
		send(wrong_path, no_wb, 0);
		send(enc_j(21'h1FFFF0, 5'd11), no_wb, 0);            // jal -16
		send(wrong_path, no_wb, 0);
		send(enc_i(12'h004, 5'd3, 3'b000, 5'd12, opc_jalr), no_wb, 0); // odd sum, bit 0 cleared
		send(wrong_path, no_wb, 0);

		write_reg(5'd0, 32'hFFFF_FFFF); // must be ignored
		send(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd13, opc_op), no_wb, 0);
		send(enc_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd14, opc_op), no_wb, 0);
		w.we   = 1'b1;
		w.rd   = 5'd5;
		w.data = 32'hDEAD_BEEF;
		send(nop_instr, w, 0); // write lands while the add above decodes

		send(enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd15, opc_op), no_wb, 3);
		send(enc_b(13'h0020, 5'd1, 5'd1, 3'b000), no_wb, 2);
		send(wrong_path, no_wb, 2); // stalled with flush up
		send(enc_r(7'h20, 5'd3, 5'd1, 3'b000, 5'd15, opc_op), no_wb, 1);

		for (k = 0; k < 400; k++) begin
			r      = $random(seed);
			w.we   = r[0];
			w.rd   = r[5:1];
			w.data = $random(seed);
			send(random_instr(), w, (r[10:8] == 3'd0) ? int'(r[12:11]) + 1 : 0);
		end

		repeat (3) cycle(bubble_at(pc), no_wb, 1'b0);
		@(posedge clk);
		push_pending();
		waited = 0;
		while (exp_q.size() != 0) begin
			assert (waited < 10) else abort_run("expected payloads never left the pipeline");
			@(negedge clk);
			waited++;
		end
		@(negedge clk);
		$display("%0d valid payloads compared", checked);
		$display("All tests passed!");
		$finish;
	end

endmodule

/* files.f */
rv_isa_pkg.sv
pipe_pkg.sv
if_id_reg.sv
id_reg_file.sv
id_imm_gen.sv
id_alu_ctrl.sv
id_branch_unit.sv
id_stage.sv
decode_top.sv
tb_clkgen.sv
tb_decode_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_decode_top \
	-f files.f \
	-o vsim_decode > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/vsim_decode > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "Test failures found" "$SIM_LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
